// File: logic/frontend_defines.svh
`ifndef FRONTEND_DEFINES_SVH
`define FRONTEND_DEFINES_SVH

// Number of pair entries in the instruction queue (power of two)
`define FE_QUEUE_DEPTH 8

// First fetch address after reset
`define FE_RESET_PC 32'h0000_1000

// Word, immediate and address width
`define FE_XLEN 32

`endif

// File: logic/rv32i_pkg.sv
`default_nettype none
`include "frontend_defines.svh"

package rv32i_pkg;

    // Raw instruction as returned by the memory port
    typedef logic [`FE_XLEN-1:0] inst_word_t;

    // Sign-extended immediate already shifted into place
    typedef logic [`FE_XLEN-1:0] imm_t;

    // Architectural register number x0..x31
    typedef logic [4:0] reg_idx_t;

    // Minor opcode fields
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // Major opcodes of the base integer set
    // Every one ends in 2'b11 since there are no compressed forms
    typedef enum logic [6:0] {
        LUI      = 7'b0110111,
        AUIPC    = 7'b0010111,
        JAL      = 7'b1101111,
        JALR     = 7'b1100111,
        BRANCH   = 7'b1100011,
        LOAD     = 7'b0000011,
        STORE    = 7'b0100011,
        OP_IMM   = 7'b0010011,
        OP       = 7'b0110011,
        MISC_MEM = 7'b0001111,
        SYSTEM   = 7'b1110011
    } opcode_e;

    // High when the low seven bits name a supported major opcode
    function automatic logic is_known_opcode(logic [6:0] op_bits);
        logic known;
        known = 1'b0;
        // Compressed and reserved quadrants never end in 11
        if (op_bits[1:0] == 2'b11) begin
            case (op_bits)
                LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE,
                OP_IMM, OP, MISC_MEM, SYSTEM: known = 1'b1;
                default: known = 1'b0;
            endcase
        end
        return known;
    endfunction

endpackage : rv32i_pkg

`default_nettype wire

// File: logic/frontend_pkg.sv
`default_nettype none
`include "frontend_defines.svh"

package frontend_pkg;

    // Byte address of an instruction word
    typedef logic [`FE_XLEN-1:0] addr_t;

    // Queue head and tail index
    // Wraps by itself because the depth is a power of two
    typedef logic [$clog2(`FE_QUEUE_DEPTH)-1:0] qptr_t;

    // Occupancy needs one extra bit to hold the full depth
    typedef logic [$clog2(`FE_QUEUE_DEPTH):0] qcount_t;

    // Fetch FSM
    typedef enum logic [1:0] {
        IDLE,   // gap cycle after reset or after a response
        REQ,    // request open on the memory port
        STALL   // waiting for room in the queue
    } fetch_state_e;

endpackage : frontend_pkg

`default_nettype wire

// File: logic/fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none
`include "frontend_defines.svh"

module fetch_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv32i_pkg::inst_word_t imem_rdata,
    input  logic                  imem_resp,
    input  logic                  queue_full,
    output frontend_pkg::addr_t   imem_addr,
    output logic [3:0]            imem_rmask,
    output logic                  fetch_valid,
    output frontend_pkg::addr_t   fetch_pc,
    output rv32i_pkg::inst_word_t fetch_word
);
    import frontend_pkg::*;

    fetch_state_e state;
    fetch_state_e state_next;
    addr_t        pc;

    // Next state
    // A request stays open until its response, never withdrawn
    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                // Queue may still be filling from the last word
                state_next = queue_full ? STALL : REQ;
            end
            REQ: begin
                if (imem_resp) begin
                    state_next = IDLE;
                end
            end
            STALL: begin
                if (!queue_full) begin
                    state_next = REQ;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    // FSM and PC
    // First request opens on the first edge after reset release
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            pc    <= `FE_RESET_PC;
        end else begin
            state <= state_next;
            // Sequential fetch only, no redirects
            if (fetch_valid) begin
                pc <= pc + addr_t'(4);
            end
        end
    end

    // Address only moves on a response so it holds for the whole request
    assign imem_addr  = pc;
    assign imem_rmask = (state == REQ) ? 4'hF : 4'h0;

    // Response cycle hands the word straight to decode
    assign fetch_valid = (state == REQ) && imem_resp;
    assign fetch_pc    = pc;
    assign fetch_word  = imem_rdata;

endmodule : fetch_unit

`default_nettype wire

// File: logic/decode_unit.sv
`timescale 1ns/10ps
`default_nettype none

module decode_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  fetch_valid,
    input  frontend_pkg::addr_t   fetch_pc,
    input  rv32i_pkg::inst_word_t fetch_word,
    output logic                  dec_valid,
    output frontend_pkg::addr_t   dec_pc,
    output rv32i_pkg::opcode_e    dec_opcode,
    output rv32i_pkg::reg_idx_t   dec_rd,
    output rv32i_pkg::reg_idx_t   dec_rs1,
    output rv32i_pkg::reg_idx_t   dec_rs2,
    output rv32i_pkg::funct3_t    dec_funct3,
    output rv32i_pkg::funct7_t    dec_funct7,
    output rv32i_pkg::imm_t       dec_imm,
    output logic                  dec_illegal
);
    import rv32i_pkg::*;

    inst_word_t word_q;

    // Valid strobe delayed by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= fetch_valid;
        end
    end

    // Capture word and PC in the response cycle
    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            word_q <= fetch_word;
            dec_pc <= fetch_pc;
        end
    end

    // Fixed field positions
    // Raw slices pass through even for illegal words
    assign dec_opcode = opcode_e'(word_q[6:0]);
    assign dec_rd     = word_q[11:7];
    assign dec_funct3 = word_q[14:12];
    assign dec_rs1    = word_q[19:15];
    assign dec_rs2    = word_q[24:20];
    assign dec_funct7 = word_q[31:25];

    assign dec_illegal = !is_known_opcode(word_q[6:0]);

    // Immediate by format with bit 31 as the sign
    always_comb begin
        case (dec_opcode)
            // I format
            LOAD, OP_IMM, JALR, SYSTEM: begin
                dec_imm = {{20{word_q[31]}}, word_q[31:20]};
            end
            // S format splits the low bits around rd
            STORE: begin
                dec_imm = {{20{word_q[31]}}, word_q[31:25], word_q[11:7]};
            end
            // B format with a halfword offset
            BRANCH: begin
                dec_imm = {{20{word_q[31]}}, word_q[7], word_q[30:25],
                           word_q[11:8], 1'b0};
            end
            // U format fills the upper 20 bits
            LUI, AUIPC: begin
                dec_imm = {word_q[31:12], 12'b0};
            end
            // J format with a halfword offset
            JAL: begin
                dec_imm = {{12{word_q[31]}}, word_q[19:12], word_q[20],
                           word_q[30:21], 1'b0};
            end
            // OP, MISC_MEM and unknown encodings
            default: dec_imm = '0;
        endcase
    end

endmodule : decode_unit

`default_nettype wire

// File: logic/pair_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module pair_buffer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                dec_valid,
    input  frontend_pkg::addr_t dec_pc,
    input  rv32i_pkg::opcode_e  dec_opcode,
    input  rv32i_pkg::reg_idx_t dec_rd,
    input  rv32i_pkg::reg_idx_t dec_rs1,
    input  rv32i_pkg::reg_idx_t dec_rs2,
    input  rv32i_pkg::funct3_t  dec_funct3,
    input  rv32i_pkg::funct7_t  dec_funct7,
    input  rv32i_pkg::imm_t     dec_imm,
    input  logic                dec_illegal,
    output logic                pair_push,
    output frontend_pkg::addr_t p0_pc, p1_pc,
    output rv32i_pkg::opcode_e  p0_opcode, p1_opcode,
    output rv32i_pkg::reg_idx_t p0_rd, p1_rd,
    output rv32i_pkg::reg_idx_t p0_rs1, p1_rs1,
    output rv32i_pkg::reg_idx_t p0_rs2, p1_rs2,
    output rv32i_pkg::funct3_t  p0_funct3, p1_funct3,
    output rv32i_pkg::funct7_t  p0_funct7, p1_funct7,
    output rv32i_pkg::imm_t     p0_imm, p1_imm,
    output logic                p0_illegal, p1_illegal
);
    import rv32i_pkg::*;
    import frontend_pkg::*;

    // Older instruction waiting for its partner
    logic     have_first;
    addr_t    hold_pc;
    opcode_e  hold_opcode;
    reg_idx_t hold_rd, hold_rs1, hold_rs2;
    funct3_t  hold_funct3;
    funct7_t  hold_funct7;
    imm_t     hold_imm;
    logic     hold_illegal;

    // Toggle on every decoded word and push when the pair completes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            have_first <= 1'b0;
            pair_push  <= 1'b0;
        end else begin
            pair_push <= dec_valid && have_first;
            if (dec_valid) begin
                have_first <= !have_first;
            end
        end
    end

    always_ff @(posedge clk) begin
        // First of the pair parks here
        if (dec_valid && !have_first) begin
            hold_pc      <= dec_pc;
            hold_opcode  <= dec_opcode;
            hold_rd      <= dec_rd;
            hold_rs1     <= dec_rs1;
            hold_rs2     <= dec_rs2;
            hold_funct3  <= dec_funct3;
            hold_funct7  <= dec_funct7;
            hold_imm     <= dec_imm;
            hold_illegal <= dec_illegal;
        end
        // Second arrives and slot 0 gets the older one
        if (dec_valid && have_first) begin
            p0_pc      <= hold_pc;
            p0_opcode  <= hold_opcode;
            p0_rd      <= hold_rd;
            p0_rs1     <= hold_rs1;
            p0_rs2     <= hold_rs2;
            p0_funct3  <= hold_funct3;
            p0_funct7  <= hold_funct7;
            p0_imm     <= hold_imm;
            p0_illegal <= hold_illegal;
            p1_pc      <= dec_pc;
            p1_opcode  <= dec_opcode;
            p1_rd      <= dec_rd;
            p1_rs1     <= dec_rs1;
            p1_rs2     <= dec_rs2;
            p1_funct3  <= dec_funct3;
            p1_funct7  <= dec_funct7;
            p1_imm     <= dec_imm;
            p1_illegal <= dec_illegal;
        end
    end

endmodule : pair_buffer

`default_nettype wire

// File: logic/inst_queue.sv
`timescale 1ns/10ps
`default_nettype none
`include "frontend_defines.svh"

module inst_queue (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                pair_push,
    input  frontend_pkg::addr_t p0_pc, p1_pc,
    input  rv32i_pkg::opcode_e  p0_opcode, p1_opcode,
    input  rv32i_pkg::reg_idx_t p0_rd, p1_rd,
    input  rv32i_pkg::reg_idx_t p0_rs1, p1_rs1,
    input  rv32i_pkg::reg_idx_t p0_rs2, p1_rs2,
    input  rv32i_pkg::funct3_t  p0_funct3, p1_funct3,
    input  rv32i_pkg::funct7_t  p0_funct7, p1_funct7,
    input  rv32i_pkg::imm_t     p0_imm, p1_imm,
    input  logic                p0_illegal, p1_illegal,
    input  logic                deq_ready,
    output logic                queue_full,
    output logic                deq_valid,
    output frontend_pkg::addr_t q0_pc, q1_pc,
    output rv32i_pkg::opcode_e  q0_opcode, q1_opcode,
    output rv32i_pkg::reg_idx_t q0_rd, q1_rd,
    output rv32i_pkg::reg_idx_t q0_rs1, q1_rs1,
    output rv32i_pkg::reg_idx_t q0_rs2, q1_rs2,
    output rv32i_pkg::funct3_t  q0_funct3, q1_funct3,
    output rv32i_pkg::funct7_t  q0_funct7, q1_funct7,
    output rv32i_pkg::imm_t     q0_imm, q1_imm,
    output logic                q0_illegal, q1_illegal
);
    import rv32i_pkg::*;
    import frontend_pkg::*;

    // Bits of one decoded instruction as stored
    localparam int SLOT_W = $bits(addr_t) + $bits(opcode_e) + 3 * $bits(reg_idx_t)
                          + $bits(funct3_t) + $bits(funct7_t) + $bits(imm_t) + 1;

    logic [2*SLOT_W-1:0] entries [`FE_QUEUE_DEPTH];
    qptr_t               head;
    qptr_t               tail;
    qcount_t             count;
    logic                pop;
    // Opcodes leave storage as plain bits and get cast back
    logic [6:0]          q0_op_bits, q1_op_bits;

    assign deq_valid = (count != '0);
    assign pop       = deq_valid && deq_ready;

    // Room for the pair that may still be in flight
    assign queue_full = (count >= qcount_t'(`FE_QUEUE_DEPTH - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (pair_push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            case ({pair_push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Slot 1 in the upper half
    always_ff @(posedge clk) begin
        if (pair_push) begin
            entries[tail] <= {p1_pc, p1_opcode, p1_rd, p1_rs1, p1_rs2,
                              p1_funct3, p1_funct7, p1_imm, p1_illegal,
                              p0_pc, p0_opcode, p0_rd, p0_rs1, p0_rs2,
                              p0_funct3, p0_funct7, p0_imm, p0_illegal};
        end
    end

    // Head entry drives the output and stays until popped
    assign {q1_pc, q1_op_bits, q1_rd, q1_rs1, q1_rs2,
            q1_funct3, q1_funct7, q1_imm, q1_illegal,
            q0_pc, q0_op_bits, q0_rd, q0_rs1, q0_rs2,
            q0_funct3, q0_funct7, q0_imm, q0_illegal} = entries[head];

    assign q0_opcode = opcode_e'(q0_op_bits);
    assign q1_opcode = opcode_e'(q1_op_bits);

endmodule : inst_queue

`default_nettype wire

// File: logic/cpu_frontend.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_frontend (
    input  logic                  clk,
    input  logic                  rst_n,
    // Instruction memory port
    output frontend_pkg::addr_t   imem_addr,
    output logic [3:0]            imem_rmask,
    input  rv32i_pkg::inst_word_t imem_rdata,
    input  logic                  imem_resp,
    // Pair output towards dispatch
    input  logic                  deq_ready,
    output logic                  deq_valid,
    output frontend_pkg::addr_t   q0_pc, q1_pc,
    output rv32i_pkg::opcode_e    q0_opcode, q1_opcode,
    output rv32i_pkg::reg_idx_t   q0_rd, q1_rd,
    output rv32i_pkg::reg_idx_t   q0_rs1, q1_rs1,
    output rv32i_pkg::reg_idx_t   q0_rs2, q1_rs2,
    output rv32i_pkg::funct3_t    q0_funct3, q1_funct3,
    output rv32i_pkg::funct7_t    q0_funct7, q1_funct7,
    output rv32i_pkg::imm_t       q0_imm, q1_imm,
    output logic                  q0_illegal, q1_illegal
);
    import rv32i_pkg::*;
    import frontend_pkg::*;

    // Fetch to decode plus the stall back from the queue
    logic       fetch_valid;
    addr_t      fetch_pc;
    inst_word_t fetch_word;
    logic       queue_full;

    // Decode to pairing
    logic       dec_valid;
    addr_t      dec_pc;
    opcode_e    dec_opcode;
    reg_idx_t   dec_rd, dec_rs1, dec_rs2;
    funct3_t    dec_funct3;
    funct7_t    dec_funct7;
    imm_t       dec_imm;
    logic       dec_illegal;

    // Pairing to queue
    logic       pair_push;
    addr_t      p0_pc, p1_pc;
    opcode_e    p0_opcode, p1_opcode;
    reg_idx_t   p0_rd, p1_rd, p0_rs1, p1_rs1, p0_rs2, p1_rs2;
    funct3_t    p0_funct3, p1_funct3;
    funct7_t    p0_funct7, p1_funct7;
    imm_t       p0_imm, p1_imm;
    logic       p0_illegal, p1_illegal;

    // Port names match the nets above one to one
    fetch_unit  fetch_i  (.*);
    decode_unit decode_i (.*);
    pair_buffer pair_i   (.*);
    inst_queue  queue_i  (.*);

endmodule : cpu_frontend

`default_nettype wire

// File: test/frontend_assert.sv
`timescale 1ns/10ps
`default_nettype none
`include "frontend_defines.svh"

module frontend_assert #(
    // Width of one queue entry holding two decoded slots side by side
    parameter int SLOT_W = $bits(frontend_pkg::addr_t) + $bits(rv32i_pkg::opcode_e)
                         + 3 * $bits(rv32i_pkg::reg_idx_t) + $bits(rv32i_pkg::funct3_t)
                         + $bits(rv32i_pkg::funct7_t) + $bits(rv32i_pkg::imm_t) + 1
) (
    input logic                    clk,
    input logic                    rst_n,
    input frontend_pkg::addr_t     imem_addr,
    input logic [3:0]              imem_rmask,
    input logic                    imem_resp,
    input frontend_pkg::qcount_t   count,
    input logic                    deq_valid,
    input logic                    deq_ready,
    input logic [2*SLOT_W-1:0]     head_entry
);
    import frontend_pkg::*;

    // Open request keeps its address until the response cycle
    a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (imem_rmask != 4'h0 && !imem_resp) |=> (imem_rmask != 4'h0 && $stable(imem_addr)))
    else $error("imem_addr or imem_rmask moved before the memory response");

    // Occupancy bounded by the number of entries
    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
        count <= qcount_t'(`FE_QUEUE_DEPTH))
    else $error("queue count above depth");

    // Stalled head pair must not change under the consumer
    a_head_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (deq_valid && !deq_ready) |=> (deq_valid && $stable(head_entry)))
    else $error("queue head fields changed while stalled");

endmodule : frontend_assert

// Queue side with the memory port tied off
bind inst_queue frontend_assert queue_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_addr  ('0),
    .imem_rmask (4'h0),
    .imem_resp  (1'b0),
    .count      (count),
    .deq_valid  (deq_valid),
    .deq_ready  (deq_ready),
    .head_entry (entries[head])
);

// Fetch side with the queue signals tied off
bind fetch_unit frontend_assert fetch_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_addr  (imem_addr),
    .imem_rmask (imem_rmask),
    .imem_resp  (imem_resp),
    .count      ('0),
    .deq_valid  (1'b0),
    .deq_ready  (1'b0),
    .head_entry ('0)
);

`default_nettype wire

// File: test/frontend_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "frontend_defines.svh"

module frontend_tb;
    import rv32i_pkg::*;
    import frontend_pkg::*;

    localparam int MEM_WORDS = 256;
    localparam int NUM_PAIRS = MEM_WORDS / 2;
    // Every word at worst latency times three for back-pressure in ns
    localparam int WATCHDOG_NS = MEM_WORDS * 5 * 3 * 10;

    logic       clk;
    logic       rst_n;
    addr_t      imem_addr;
    logic [3:0] imem_rmask;
    inst_word_t imem_rdata;
    logic       imem_resp;
    logic       deq_ready;
    logic       deq_valid;
    addr_t      q0_pc, q1_pc;
    opcode_e    q0_opcode, q1_opcode;
    reg_idx_t   q0_rd, q1_rd, q0_rs1, q1_rs1, q0_rs2, q1_rs2;
    funct3_t    q0_funct3, q1_funct3;
    funct7_t    q0_funct7, q1_funct7;
    imm_t       q0_imm, q1_imm;
    logic       q0_illegal, q1_illegal;

    // Instruction image with word i at FE_RESET_PC + 4*i
    inst_word_t mem [MEM_WORDS];
    const opcode_e op_list [11] = '{LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE,
                                    OP_IMM, OP, MISC_MEM, SYSTEM};
    // Slot 0 PC of every pair still to be popped
    addr_t exp_pcs [$];

    int checks = 0;
    int errors = 0;
    int pairs_done = 0;
    int illegal_seen = 0;
    int neg_imm_seen = 0;
    int full_cycles = 0;

    cpu_frontend uut (.*);

    initial begin : clock_gen
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Membership in the supported opcode list
    function automatic logic opcode_known(logic [6:0] bits7);
        logic hit;
        hit = 1'b0;
        foreach (op_list[k]) begin
            if (bits7 == op_list[k]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // ISA immediate layout per format with zero for unknown opcodes
    function automatic imm_t expected_imm(inst_word_t w);
        imm_t imm;
        imm = '0;
        if (opcode_known(w[6:0])) begin
            case (opcode_e'(w[6:0]))
                LOAD, OP_IMM, JALR, SYSTEM: imm = {{20{w[31]}}, w[31:20]};
                STORE:      imm = {{20{w[31]}}, w[31:25], w[11:7]};
                BRANCH:     imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                LUI, AUIPC: imm = {w[31:12], 12'h000};
                JAL:        imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                default:    imm = '0;
            endcase
        end
        return imm;
    endfunction

    function automatic int word_index(addr_t a);
        addr_t off;
        off = a - addr_t'(`FE_RESET_PC);
        return int'(off[9:2]);
    endfunction

    task automatic check_flag(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_mask(string name, logic [3:0] got, logic [3:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(string name, addr_t got, addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_opcode(string name, opcode_e got, opcode_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_reg(string name, reg_idx_t got, reg_idx_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_imm(string name, imm_t got, imm_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_fields(string name, funct3_t got3, funct7_t got7, logic got_ill,
                                funct3_t exp3, funct7_t exp7, logic exp_ill);
        checks++;
        if (got3 !== exp3 || got7 !== exp7 || got_ill !== exp_ill) begin
            errors++;
            $display("ERROR %0t %s got %h/%h/%b expected %h/%h/%b", $time, name,
                     got3, got7, got_ill, exp3, exp7, exp_ill);
        end
    endtask

    // One popped slot against the reference decode of its word
    task automatic check_slot(string slot, addr_t exp_pc, addr_t pc, opcode_e op,
                              reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2, funct3_t f3,
                              funct7_t f7, imm_t imm, logic ill);
        inst_word_t w;
        imm_t       exp_imm;
        w = mem[word_index(exp_pc)];
        exp_imm = expected_imm(w);
        check_addr({slot, "_pc"}, pc, exp_pc);
        check_opcode({slot, "_opcode"}, op, opcode_e'(w[6:0]));
        check_reg({slot, "_rd"}, rd, w[11:7]);
        check_reg({slot, "_rs1"}, rs1, w[19:15]);
        check_reg({slot, "_rs2"}, rs2, w[24:20]);
        check_imm({slot, "_imm"}, imm, exp_imm);
        check_fields({slot, "_funct3/funct7/illegal"}, f3, f7, ill,
                     w[14:12], w[31:25], !opcode_known(w[6:0]));
        if (!opcode_known(w[6:0])) begin
            illegal_seen++;
        end
        if (exp_imm[31]) begin
            neg_imm_seen++;
        end
    endtask

    // Mostly known opcodes with about one word in ten illegal
    task automatic fill_memory();
        inst_word_t w;
        for (int i = 0; i < MEM_WORDS; i++) begin
            w = $urandom();
            if ($urandom_range(9, 0) != 0) begin
                w[6:0] = op_list[$urandom_range(10, 0)];
            end else begin
                while (opcode_known(w[6:0])) begin
                    w[6:0] = 7'($urandom());
                end
            end
            mem[i] = w;
        end
    endtask

    // Memory model answering 1 to 5 cycles after the request opens
    initial begin : memory_model
        int lat;
        @(posedge rst_n);
        forever begin
            @(posedge clk);
            #1;
            imem_resp = 1'b0;
            if (imem_rmask != 4'h0) begin
                lat = $urandom_range(5, 1);
                repeat (lat - 1) begin
                    @(posedge clk);
                    #1;
                end
                imem_rdata = mem[word_index(imem_addr)];
                imem_resp  = 1'b1;
            end
        end
    end

    // Consumer ready 60 percent of the time with occasional long stalls
    initial begin : consumer
        int hold;
        hold = 0;
        @(posedge rst_n);
        forever begin
            @(posedge clk);
            #1;
            if (hold > 0) begin
                hold--;
                deq_ready = 1'b0;
            end else if ($urandom_range(99, 0) == 0) begin
                // Long enough for the queue to fill and fetch to back off
                hold = $urandom_range(80, 40);
                deq_ready = 1'b0;
            end else begin
                deq_ready = ($urandom_range(99, 0) < 60);
            end
        end
    end

    // Mid-cycle sampling while values hold until the next edge
    always @(negedge clk) begin : scoreboard
        addr_t pc0;
        logic  prev_full;
        logic  prev_req;
        if (rst_n) begin
            if (uut.queue_i.queue_full) begin
                full_cycles++;
            end
            if (imem_rmask != 4'h0 && !prev_req && prev_full) begin
                errors++;
                $display("%0t: fetch opened a request while the queue was full", $time);
            end
            prev_req  = (imem_rmask != 4'h0);
            prev_full = uut.queue_i.queue_full;
            if (deq_valid && deq_ready && exp_pcs.size() != 0) begin
                pc0 = exp_pcs.pop_front();
                check_slot("q0", pc0, q0_pc, q0_opcode, q0_rd, q0_rs1, q0_rs2,
                           q0_funct3, q0_funct7, q0_imm, q0_illegal);
                check_slot("q1", pc0 + addr_t'(4), q1_pc, q1_opcode, q1_rd, q1_rs1, q1_rs2,
                           q1_funct3, q1_funct7, q1_imm, q1_illegal);
                pairs_done++;
            end
        end else begin
            prev_req  = 1'b0;
            prev_full = 1'b0;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: %0d of %0d pairs arrived before the watchdog expired",
                 pairs_done, NUM_PAIRS);
        $display("Result: FAILED");
        $finish;
    end

    initial begin : main
        int errs_before;
        void'($urandom(87));
        rst_n      = 1'b0;
        imem_rdata = '0;
        imem_resp  = 1'b0;
        deq_ready  = 1'b0;
        fill_memory();
        for (int k = 0; k < NUM_PAIRS; k++) begin
            exp_pcs.push_back(addr_t'(`FE_RESET_PC + 8 * k));
        end

        // Reset state and then the first request right after release
        errs_before = errors;
        repeat (2) @(posedge clk);
        #1;
        check_flag("deq_valid", deq_valid, 1'b0);
        check_mask("imem_rmask", imem_rmask, 4'h0);
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        check_mask("imem_rmask", imem_rmask, 4'hF);
        check_addr("imem_addr", imem_addr, addr_t'(`FE_RESET_PC));
        $display("test reset_state: %0d errors", errors - errs_before);

        // Whole image through the queue under random back-pressure
        errs_before = errors;
        wait (pairs_done == NUM_PAIRS);
        if (full_cycles == 0) begin
            errors++;
            $display("back-pressure never filled the queue");
        end
        if (illegal_seen == 0) begin
            errors++;
            $display("no illegal word reached the queue output");
        end
        if (neg_imm_seen == 0) begin
            errors++;
            $display("no negative immediate reached the queue output");
        end
        $display("test pair_stream: %0d pairs, %0d illegal, %0d negative imm, %0d full, %0d errors",
                 pairs_done, illegal_seen, neg_imm_seen, full_cycles, errors - errs_before);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule : frontend_tb

`default_nettype wire

// File: src.f
+incdir+logic
logic/rv32i_pkg.sv
logic/frontend_pkg.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/pair_buffer.sv
logic/inst_queue.sv
logic/cpu_frontend.sv
test/frontend_assert.sv
test/frontend_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the front end testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module frontend_tb -f src.f

# Simulator exit status is not trusted, the log decides
./obj_dir/Vfrontend_tb 2>&1 | tee sim.log

if grep -q "^Result: PASSED$" sim.log; then
    exit 0
else
    exit 1
fi
